/* common/ipdc_cfg.svh */
`ifndef IPDC_CFG_SVH
`define IPDC_CFG_SVH

// Map geometry
`define IPDC_MAP_COL    8
`define IPDC_MAP_ROW    8
`define IPDC_MAP_WORDS  2048

// Depth limits
`define IPDC_DEPTH_MAX  32
`define IPDC_DEPTH_MIN  8

// Origin clamp and median channels
`define IPDC_ORIGIN_MAX 6
`define IPDC_MED_CH     4

`endif

/* common/ipdc_op_pkg.sv */
package ipdc_op_pkg;

	// Opcodes on i_op_mode
	typedef enum logic [3:0] {
		OP_LOAD       = 4'd0,
		OP_RIGHT      = 4'd1,
		OP_LEFT       = 4'd2,
		OP_UP         = 4'd3,
		OP_DOWN       = 4'd4,
		OP_SCALE_DOWN = 4'd5,
		OP_SCALE_UP   = 4'd6,
		OP_DISPLAY    = 4'd7,
		OP_CONV       = 4'd8,
		OP_MEDIAN     = 4'd9,
		OP_SOBEL      = 4'd10
	} op_mode_t;

	// Controller FSM states
	typedef enum logic [2:0] {
		FETCH   = 3'd0,
		DECODE  = 3'd1,
		LOAD    = 3'd2,
		DISPLAY = 3'd3,
		MEDIAN  = 3'd4,
		DRAIN   = 3'd5
	} ctrl_state_t;

endpackage

/* common/ipdc_pix_pkg.sv */
package ipdc_pix_pkg;

	// One map pixel
	typedef logic [7:0] pixel_t;

	// Output word, pixel zero-extended
	typedef logic [13:0] out_word_t;

	// x + 8*y + 64*z
	typedef logic [10:0] map_addr_t;

	// Origin x and y
	typedef logic [2:0] coord_t;

	typedef logic [5:0] depth_t;

	// 4x4 window slot, row-major
	typedef logic [3:0] win_idx_t;

endpackage

/* hdl/ipdc_core.sv */
`timescale 1ns/10ps

module ipdc_core (
	input  logic                    i_clk,
	input  logic                    i_rst_n,
	input  logic                    i_op_valid,
	input  ipdc_op_pkg::op_mode_t   i_op_mode,
	output logic                    o_op_ready,
	input  logic                    i_in_valid,
	input  ipdc_pix_pkg::pixel_t    i_in_data,
	output logic                    o_in_ready,
	output logic                    o_out_valid,
	output ipdc_pix_pkg::out_word_t o_out_data
);
	import ipdc_pix_pkg::*;

	// Memory port
	logic      mem_cen;
	logic      mem_wen;
	map_addr_t mem_addr;
	pixel_t    mem_wdata;
	pixel_t    mem_rdata;

	// Median window port
	logic      win_we;
	logic      win_zero;
	win_idx_t  win_idx;
	pixel_t    med [4];

	ipdc_ctrl ipdc_ctrl_i (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_op_valid  (i_op_valid),
		.i_op_mode   (i_op_mode),
		.o_op_ready  (o_op_ready),
		.i_in_valid  (i_in_valid),
		.i_in_data   (i_in_data),
		.o_in_ready  (o_in_ready),
		.o_out_valid (o_out_valid),
		.o_out_data  (o_out_data),
		.o_mem_cen   (mem_cen),
		.o_mem_wen   (mem_wen),
		.o_mem_addr  (mem_addr),
		.o_mem_wdata (mem_wdata),
		.i_mem_rdata (mem_rdata),
		.o_win_we    (win_we),
		.o_win_zero  (win_zero),
		.o_win_idx   (win_idx),
		.i_med       (med)
	);

	map_sram map_sram_i (
		.i_clk   (i_clk),
		.i_cen   (mem_cen),
		.i_wen   (mem_wen),
		.i_addr  (mem_addr),
		.i_wdata (mem_wdata),
		.o_rdata (mem_rdata)
	);

	// Read data also feeds the window, padding is selected inside
	median_window median_window_i (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_we    (win_we),
		.i_zero  (win_zero),
		.i_idx   (win_idx),
		.i_pixel (mem_rdata),
		.o_med   (med)
	);

endmodule

/* hdl/ipdc_ctrl.sv */
`timescale 1ns/10ps
`include "ipdc_cfg.svh"

module ipdc_ctrl (
	input  logic                    i_clk,
	input  logic                    i_rst_n,
	input  logic                    i_op_valid,
	input  ipdc_op_pkg::op_mode_t   i_op_mode,
	output logic                    o_op_ready,
	input  logic                    i_in_valid,
	input  ipdc_pix_pkg::pixel_t    i_in_data,
	output logic                    o_in_ready,
	output logic                    o_out_valid,
	output ipdc_pix_pkg::out_word_t o_out_data,
	output logic                    o_mem_cen,
	output logic                    o_mem_wen,
	output ipdc_pix_pkg::map_addr_t o_mem_addr,
	output ipdc_pix_pkg::pixel_t    o_mem_wdata,
	input  ipdc_pix_pkg::pixel_t    i_mem_rdata,
	output logic                    o_win_we,
	output logic                    o_win_zero,
	output ipdc_pix_pkg::win_idx_t  o_win_idx,
	input  ipdc_pix_pkg::pixel_t    i_med [4]
);
	import ipdc_op_pkg::*;
	import ipdc_pix_pkg::*;

	// Per channel: 16 slot cycles, one write cycle, then four medians
	localparam logic [4:0] WIN_SLOTS    = 5'd16;
	localparam logic [4:0] MED_LAST_SUB = WIN_SLOTS + 5'd4;

	ctrl_state_t state;
	op_mode_t    op_q;
	coord_t      org_x;
	coord_t      org_y;
	depth_t      depth;
	map_addr_t   step;

	// Delayed copy of the request
	logic        req_q;
	logic        zero_q;
	win_idx_t    idx_q;

	logic        issue;
	logic        pad;
	logic [1:0]  med_ch;
	logic [4:0]  med_sub;
	logic [1:0]  med_pick;
	win_idx_t    slot;
	logic [3:0]  tx;
	logic [3:0]  ty;
	logic        in_map;
	logic [7:0]  disp_last;

	function automatic map_addr_t pix_addr(input coord_t x, input coord_t y,
		input logic [4:0] z);
		return map_addr_t'(x + `IPDC_MAP_COL * y + `IPDC_MAP_COL * `IPDC_MAP_ROW * z);
	endfunction

	// ---------------------------------------------------------------------
	// Step decoding
	// ---------------------------------------------------------------------
	assign med_ch    = step[6:5];
	assign med_sub   = step[4:0];
	assign med_pick  = med_sub[1:0] - 2'd1;
	assign slot      = step[3:0];
	assign disp_last = {depth, 2'b00} - 8'd1;

	// Window coordinates offset by one so the left and top pads sit at zero
	assign tx     = {1'b0, org_x} + {2'b00, slot[1:0]};
	assign ty     = {1'b0, org_y} + {2'b00, slot[3:2]};
	assign in_map = (tx != 4'd0) && (tx <= 4'(`IPDC_MAP_COL)) &&
		(ty != 4'd0) && (ty <= 4'(`IPDC_MAP_ROW));

	// ---------------------------------------------------------------------
	// Memory requests
	// ---------------------------------------------------------------------
	assign o_mem_wdata = i_in_data;

	always_comb begin
		issue      = 1'b0;
		pad        = 1'b0;
		o_mem_cen  = 1'b1;
		o_mem_wen  = 1'b1;
		o_mem_addr = '0;
		case (state)
			LOAD: begin
				o_mem_cen  = ~i_in_valid;
				o_mem_wen  = 1'b0;
				o_mem_addr = step;
			end
			DISPLAY: begin
				issue      = 1'b1;
				o_mem_cen  = 1'b0;
				o_mem_addr = pix_addr(org_x + {2'b00, step[0]}, org_y + {2'b00, step[1]},
					step[6:2]);
			end
			MEDIAN: begin
				if (med_sub < WIN_SLOTS) begin
					issue      = in_map;
					pad        = ~in_map;
					o_mem_cen  = ~in_map;
					o_mem_addr = pix_addr(coord_t'(tx - 4'd1), coord_t'(ty - 4'd1),
						{3'b000, med_ch});
				end
			end
			default: begin
			end
		endcase
	end

	// ---------------------------------------------------------------------
	// Handshake, window strobes and output words
	// ---------------------------------------------------------------------
	assign o_op_ready = (state == FETCH);
	assign o_in_ready = (state == LOAD);
	assign o_win_we   = req_q && (state == MEDIAN);
	assign o_win_zero = zero_q;
	assign o_win_idx  = idx_q;

	always_comb begin
		o_out_valid = 1'b0;
		o_out_data  = out_word_t'(i_mem_rdata);
		if (state == DISPLAY || state == DRAIN) begin
			o_out_valid = req_q;
		end else if (state == MEDIAN && med_sub > WIN_SLOTS) begin
			o_out_valid = 1'b1;
			o_out_data  = out_word_t'(i_med[med_pick]);
		end
	end

	always_ff @(posedge i_clk) begin
		zero_q <= pad;
		idx_q  <= slot;
	end

	// ---------------------------------------------------------------------
	// FSM, origin and depth
	// ---------------------------------------------------------------------
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= FETCH;
			op_q  <= OP_LOAD;
			org_x <= '0;
			org_y <= '0;
			depth <= depth_t'(`IPDC_DEPTH_MAX);
			step  <= '0;
			req_q <= 1'b0;
		end else begin
			req_q <= issue | pad;
			case (state)
				FETCH: begin
					step <= '0;
					if (i_op_valid) begin
						op_q  <= i_op_mode;
						state <= DECODE;
					end
				end
				DECODE: begin
					state <= FETCH;
					case (op_q)
						OP_LOAD:    state <= LOAD;
						OP_DISPLAY: state <= DISPLAY;
						OP_MEDIAN:  state <= MEDIAN;
						OP_RIGHT: begin
							if (org_x != coord_t'(`IPDC_ORIGIN_MAX)) begin
								org_x <= org_x + 3'd1;
							end
						end
						OP_LEFT: begin
							if (org_x != '0) begin
								org_x <= org_x - 3'd1;
							end
						end
						OP_UP: begin
							if (org_y != '0) begin
								org_y <= org_y - 3'd1;
							end
						end
						OP_DOWN: begin
							if (org_y != coord_t'(`IPDC_ORIGIN_MAX)) begin
								org_y <= org_y + 3'd1;
							end
						end
						OP_SCALE_DOWN: begin
							if (depth != depth_t'(`IPDC_DEPTH_MIN)) begin
								depth <= depth >> 1;
							end
						end
						OP_SCALE_UP: begin
							if (depth != depth_t'(`IPDC_DEPTH_MAX)) begin
								depth <= depth << 1;
							end
						end
						// conv, sobel and unknown codes
						default: state <= FETCH;
					endcase
				end
				LOAD: begin
					if (i_in_valid) begin
						step <= step + 11'd1;
						if (step == map_addr_t'(`IPDC_MAP_WORDS - 1)) begin
							state <= FETCH;
						end
					end
				end
				DISPLAY: begin
					step <= step + 11'd1;
					if (step[7:0] == disp_last) begin
						state <= DRAIN;
					end
				end
				// Last read word is still in flight
				DRAIN: state <= FETCH;
				MEDIAN: begin
					if (med_sub == MED_LAST_SUB) begin
						step <= {step[10:5] + 6'd1, 5'd0};
						if (med_ch == 2'(`IPDC_MED_CH - 1)) begin
							state <= FETCH;
						end
					end else begin
						step <= step + 11'd1;
					end
				end
				default: state <= FETCH;
			endcase
		end
	end

endmodule

/* hdl/map_sram.sv */
`timescale 1ns/10ps
`include "ipdc_cfg.svh"

module map_sram (
	input  logic                    i_clk,
	input  logic                    i_cen,
	input  logic                    i_wen,
	input  ipdc_pix_pkg::map_addr_t i_addr,
	input  ipdc_pix_pkg::pixel_t    i_wdata,
	output ipdc_pix_pkg::pixel_t    o_rdata
);
	import ipdc_pix_pkg::*;

	pixel_t mem [`IPDC_MAP_WORDS];

	// Enable and write strobe both active low
	always_ff @(posedge i_clk) begin
		if (!i_cen) begin
			if (!i_wen) begin
				mem[i_addr] <= i_wdata;
			end else begin
				o_rdata <= mem[i_addr];
			end
		end
	end

endmodule

/* median/median9.sv */
`timescale 1ns/10ps

module median9 (
	input  ipdc_pix_pkg::pixel_t i_pix [9],
	output ipdc_pix_pkg::pixel_t o_median
);
	import ipdc_pix_pkg::*;

	localparam int NUM_CMP = 19;

	// Compare-exchange pairs, smaller value goes to the A slot
	localparam int SORT_A [NUM_CMP] = '{1, 4, 7, 0, 3, 6, 1, 4, 7, 0, 5, 4, 3, 1, 2, 4, 4, 6, 4};
	localparam int SORT_B [NUM_CMP] = '{2, 5, 8, 1, 4, 7, 2, 5, 8, 3, 8, 7, 6, 4, 5, 7, 2, 4, 2};

	always_comb begin
		pixel_t s [9];
		pixel_t a;
		pixel_t b;
		s = i_pix;
		for (int k = 0; k < NUM_CMP; k++) begin
			a = s[SORT_A[k]];
			b = s[SORT_B[k]];
			// equal values stay in place
			s[SORT_A[k]] = (a > b) ? b : a;
			s[SORT_B[k]] = (a > b) ? a : b;
		end
		o_median = s[4];
	end

endmodule

/* median/median_window.sv */
`timescale 1ns/10ps

module median_window (
	input  logic                   i_clk,
	input  logic                   i_rst_n,
	input  logic                   i_we,
	input  logic                   i_zero,
	input  ipdc_pix_pkg::win_idx_t i_idx,
	input  ipdc_pix_pkg::pixel_t   i_pixel,
	output ipdc_pix_pkg::pixel_t   o_med [4]
);
	import ipdc_pix_pkg::*;

	localparam int WIN_DIM   = 4;
	localparam int WIN_SLOTS = WIN_DIM * WIN_DIM;

	pixel_t win [WIN_SLOTS];
	pixel_t sub_win [4][9];

	// ---------------------------------------------------------------------
	// Window register file
	// ---------------------------------------------------------------------
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			for (int i = 0; i < WIN_SLOTS; i++) begin
				win[i] <= '0;
			end
		end else if (i_we) begin
			win[i_idx] <= i_zero ? pixel_t'(0) : i_pixel;
		end
	end

	// ---------------------------------------------------------------------
	// 3x3 sub-windows
	// ---------------------------------------------------------------------
	// Sub-window q starts at row q/2 and column q%2
	always_comb begin
		for (int q = 0; q < 4; q++) begin
			for (int k = 0; k < 9; k++) begin
				sub_win[q][k] = win[((q / 2) + (k / 3)) * WIN_DIM + (q % 2) + (k % 3)];
			end
		end
	end

	// tl, tr, bl, br
	genvar g;
	generate
		for (g = 0; g < 4; g++) begin : g_med
			median9 median9_i (
				.i_pix    (sub_win[g]),
				.o_median (o_med[g])
			);
		end
	endgenerate

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the ipdc testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --assert --timescale 1ns/10ps \
	--top-module ipdc_tb -f tb.f -o ipdc_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/ipdc_sim > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -qx "All checks passed" "$log"; then
	exit 0
fi
echo "no pass line found in $log"
exit 1

/* tb.f */
+incdir+common
common/ipdc_op_pkg.sv
common/ipdc_pix_pkg.sv
median/median9.sv
median/median_window.sv
hdl/map_sram.sv
hdl/ipdc_ctrl.sv
hdl/ipdc_core.sv
tests/ipdc_properties.sv
tests/ipdc_tb.sv

/* tests/ipdc_input.txt */
# opcode  words  origin_x  origin_y  depth   (values after the operation)
# 0 load, 1 right, 2 left, 3 up, 4 down, 5/6 scale, 7 display, 8 conv, 9 median, 10 sobel
0   0    0  0  32
7   128  0  0  32
9   16   0  0  32
2   0    0  0  32
3   0    0  0  32
7   128  0  0  32
1   0    1  0  32
4   0    1  1  32
4   0    1  2  32
9   16   1  2  32
6   0    1  2  32
5   0    1  2  16
7   64   1  2  16
5   0    1  2  8
5   0    1  2  8
7   32   1  2  8
8   0    1  2  8
10  0    1  2  8
1   0    2  2  8
1   0    3  2  8
1   0    4  2  8
1   0    5  2  8
1   0    6  2  8
1   0    6  2  8
4   0    6  3  8
4   0    6  4  8
4   0    6  5  8
4   0    6  6  8
4   0    6  6  8
7   32   6  6  8
9   16   6  6  8
6   0    6  6  16
6   0    6  6  32
6   0    6  6  32
7   128  6  6  32
11  0    6  6  32

/* tests/ipdc_properties.sv */
`timescale 1ns/10ps

module ipdc_properties (
	input logic                  i_clk,
	input logic                  i_rst_n,
	input logic                  i_op_valid,
	input ipdc_op_pkg::op_mode_t i_op_mode,
	input logic                  i_op_ready,
	input logic                  i_in_ready,
	input logic                  i_out_valid
);
	import ipdc_op_pkg::*;

	// Output words only while an operation runs
	a_out_vs_op_ready: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!(i_out_valid && i_op_ready))
		else $error("o_out_valid and o_op_ready are high together");

	// Load and output phases never overlap
	a_in_vs_out: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!(i_in_ready && i_out_valid))
		else $error("o_in_ready and o_out_valid are high together");

	// Accepted non-load op never opens the pixel input, in DECODE or after it
	a_no_load_no_in_ready: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(i_op_ready && i_op_valid && i_op_mode != OP_LOAD) |=> !i_in_ready [*2])
		else $error("o_in_ready high right after a non-load opcode");

endmodule

bind ipdc_core ipdc_properties ipdc_properties_i (
	.i_clk       (i_clk),
	.i_rst_n     (i_rst_n),
	.i_op_valid  (i_op_valid),
	.i_op_mode   (i_op_mode),
	.i_op_ready  (o_op_ready),
	.i_in_ready  (o_in_ready),
	.i_out_valid (o_out_valid)
);

/* tests/ipdc_tb.sv */
`timescale 1ns/10ps
`include "ipdc_cfg.svh"

module ipdc_tb;
	import ipdc_op_pkg::*;
	import ipdc_pix_pkg::*;

	localparam logic [31:0] LFSR_SEED = 32'h4014;
	localparam int WAIT_LIMIT = 1000;
	localparam int LOAD_LIMIT = 8 * `IPDC_MAP_WORDS;

	logic      i_clk = 1'b0;
	logic      i_rst_n;
	logic      i_op_valid;
	op_mode_t  i_op_mode;
	logic      o_op_ready;
	logic      i_in_valid;
	pixel_t    i_in_data;
	logic      o_in_ready;
	logic      o_out_valid;
	out_word_t o_out_data;

	// Reference map and registers
	pixel_t    map_ref [`IPDC_MAP_WORDS];
	int        mx;
	int        my;
	int        mdepth;
	int        exp_q [$];
	out_word_t got_q [$];

	logic [31:0] lfsr;
	int          errors;
	int          failures;
	int          fd;
	string       line;
	logic [3:0]  op;
	int          cnt;
	int          ex;
	int          ey;
	int          ed;

	ipdc_core ipdc_core_i (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_op_valid  (i_op_valid),
		.i_op_mode   (i_op_mode),
		.o_op_ready  (o_op_ready),
		.i_in_valid  (i_in_valid),
		.i_in_data   (i_in_data),
		.o_in_ready  (o_in_ready),
		.o_out_valid (o_out_valid),
		.o_out_data  (o_out_data)
	);

	always #5 i_clk = ~i_clk;

	// Output words collected away from the clock edge
	always @(negedge i_clk) begin
		if (i_rst_n && o_out_valid) begin
			got_q.push_back(o_out_data);
		end
	end

	// ----------------------------------------------------------------------
	// Random source and reference model
	// ----------------------------------------------------------------------
	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic int rand_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = (v << 1) | int'(lfsr[0]);
		end
		return v;
	endfunction

	function automatic int addr_of(input int x, input int y, input int z);
		return x + `IPDC_MAP_COL * y + `IPDC_MAP_COL * `IPDC_MAP_ROW * z;
	endfunction

	// Zero outside the map
	function automatic int pixel_or_pad(input int x, input int y, input int z);
		if (x < 0 || x >= `IPDC_MAP_COL || y < 0 || y >= `IPDC_MAP_ROW) begin
			return 0;
		end
		return int'(map_ref[map_addr_t'(addr_of(x, y, z))]);
	endfunction

	function automatic int median_at(input int cx, input int cy, input int z);
		int v [$];
		for (int dy = -1; dy <= 1; dy++) begin
			for (int dx = -1; dx <= 1; dx++) begin
				v.push_back(pixel_or_pad(cx + dx, cy + dy, z));
			end
		end
		v.sort();
		return v[4];
	endfunction

	task automatic predict_op(input logic [3:0] code);
		case (code)
			OP_RIGHT: begin
				if (mx < `IPDC_ORIGIN_MAX) begin
					mx++;
				end
			end
			OP_LEFT: begin
				if (mx > 0) begin
					mx--;
				end
			end
			OP_UP: begin
				if (my > 0) begin
					my--;
				end
			end
			OP_DOWN: begin
				if (my < `IPDC_ORIGIN_MAX) begin
					my++;
				end
			end
			OP_SCALE_DOWN: begin
				if (mdepth > `IPDC_DEPTH_MIN) begin
					mdepth = mdepth / 2;
				end
			end
			OP_SCALE_UP: begin
				if (mdepth < `IPDC_DEPTH_MAX) begin
					mdepth = mdepth * 2;
				end
			end
			// Patch order tl, tr, bl, br inside each channel
			OP_DISPLAY: begin
				for (int z = 0; z < mdepth; z++) begin
					for (int p = 0; p < 4; p++) begin
						exp_q.push_back(pixel_or_pad(mx + p % 2, my + p / 2, z));
					end
				end
			end
			OP_MEDIAN: begin
				for (int z = 0; z < `IPDC_MED_CH; z++) begin
					for (int p = 0; p < 4; p++) begin
						exp_q.push_back(median_at(mx + p % 2, my + p / 2, z));
					end
				end
			end
			default: begin
			end
		endcase
	endtask

	// ----------------------------------------------------------------------
	// Checks and DUT handshakes
	// ----------------------------------------------------------------------
	task automatic check_value(input int got, input int exp, input string what);
		if (got != exp) begin
			$display("error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic wait_op_ready();
		int n;
		n = 0;
		if (failures != 0) begin
			return;
		end
		while (!o_op_ready && n < WAIT_LIMIT) begin
			@(negedge i_clk);
			n++;
		end
		if (!o_op_ready) begin
			$display("timeout at %0t: o_op_ready did not come back", $time);
			failures++;
		end
	endtask

	task automatic await_load_start();
		int n;
		n = 0;
		while (!o_in_ready && n < WAIT_LIMIT) begin
			@(negedge i_clk);
			n++;
		end
		if (!o_in_ready) begin
			$display("timeout at %0t: o_in_ready never went high for the load", $time);
			failures++;
		end
	endtask

	task automatic send_op(input logic [3:0] code);
		@(posedge i_clk);
		#1;
		i_op_valid = 1'b1;
		i_op_mode  = op_mode_t'(code);
		@(posedge i_clk);
		#1;
		i_op_valid = 1'b0;
	endtask

	// Raster order with random gaps in i_in_valid
	task automatic load_map();
		int idx;
		int cycles;
		idx = 0;
		cycles = 0;
		await_load_start();
		if (failures != 0) begin
			return;
		end
		while (idx < `IPDC_MAP_WORDS && cycles < LOAD_LIMIT) begin
			@(posedge i_clk);
			#1;
			if (rand_bits(2) == 0) begin
				i_in_valid = 1'b0;
			end else begin
				check_value(int'(o_in_ready), 1, "o_in_ready during load");
				i_in_valid = 1'b1;
				i_in_data  = map_ref[map_addr_t'(idx)];
				idx++;
			end
			cycles++;
		end
		@(posedge i_clk);
		#1;
		i_in_valid = 1'b0;
		if (idx < `IPDC_MAP_WORDS) begin
			$display("load stopped after %0d of %0d pixels", idx, `IPDC_MAP_WORDS);
			failures++;
		end
	endtask

	task automatic run_op(input logic [3:0] code, input int words, input int x,
		input int y, input int d);
		got_q.delete();
		exp_q.delete();
		predict_op(code);
		send_op(code);
		if (code == OP_LOAD) begin
			load_map();
		end
		wait_op_ready();
		check_value(mx, x, "reference origin x");
		check_value(my, y, "reference origin y");
		check_value(mdepth, d, "reference depth");
		check_value(exp_q.size(), words, "reference word count");
		check_value(got_q.size(), words, $sformatf("word count of op %0d", code));
		for (int i = 0; i < got_q.size() && i < exp_q.size(); i++) begin
			check_value(int'(got_q[i]), exp_q[i], $sformatf("op %0d word %0d", code, i));
		end
	endtask

	// ----------------------------------------------------------------------
	// Main sequence
	// ----------------------------------------------------------------------
	initial begin
		i_rst_n    = 1'b0;
		i_op_valid = 1'b0;
		i_op_mode  = OP_LOAD;
		i_in_valid = 1'b0;
		i_in_data  = '0;
		errors     = 0;
		failures   = 0;
		lfsr       = LFSR_SEED;
		mx         = 0;
		my         = 0;
		mdepth     = `IPDC_DEPTH_MAX;
		for (int a = 0; a < `IPDC_MAP_WORDS; a++) begin
			map_ref[map_addr_t'(a)] = pixel_t'(rand_bits(8));
		end

		repeat (5) @(posedge i_clk);
		#1;
		i_rst_n = 1'b1;
		@(negedge i_clk);
		check_value(int'(o_op_ready), 1, "o_op_ready after reset");
		check_value(int'(o_in_ready), 0, "o_in_ready after reset");
		check_value(int'(o_out_valid), 0, "o_out_valid after reset");

		fd = $fopen("tests/ipdc_input.txt", "r");
		if (fd == 0) begin
			$display("could not open the operation file tests/ipdc_input.txt");
			failures++;
		end else begin
			while (!$feof(fd) && failures == 0) begin
				if ($fgets(line, fd) != 0) begin
					if ($sscanf(line, "%d %d %d %d %d", op, cnt, ex, ey, ed) == 5) begin
						run_op(op, cnt, ex, ey, ed);
					end
				end
			end
			$fclose(fd);
		end

		$display("mismatches: %0d, other failures: %0d", errors, failures);
		if (errors == 0 && failures == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule
